// ==== bench/garble_model.svh ====
/*
 * Reference model for the free-XOR garbler testbench, included inside the
 * testbench module. It steps its own copy of the label LFSR and garbles the
 * gate queues of the testbench into the expected R, input labels and mask.
 */
`ifndef GARBLE_MODEL_SVH
`define GARBLE_MODEL_SVH

localparam label_t REF_SEED = 32'h0000_0001;
localparam label_t REF_TAPS = 32'h8020_0003;

label_t ref_lfsr;     // Runs on across rows, never reseeded after reset
label_t ref_wire [$]; // Zero-labels by wire number
label_t exp_r;
label_t exp_in [$];
label_t exp_mask;

// One step: shift right, fold in the taps when a one drops out
function automatic label_t next_ref_label();
	label_t s;
	s = ref_lfsr;
	ref_lfsr = {1'b0, s[31:1]} ^ (s[0] ? REF_TAPS : 32'h0);
	return ref_lfsr;
endfunction

function automatic void build_expected(int n_in, int n_gates, int n_out);
	label_t a;
	label_t b;
	exp_r = next_ref_label() | 32'h1; // R always has bit 0 set
	exp_in.delete();
	ref_wire.delete();
	for (int i = 0; i < n_in; i++) begin
		exp_in.push_back(next_ref_label());
		ref_wire.push_back(exp_in[i]);
	end
	// Gate j lands on wire n_in + j, pushed in order
	for (int j = 0; j < n_gates; j++) begin
		a = ref_wire[g_in0[j]];
		b = ref_wire[g_in1[j]];
		case (g_op[j])
			OP_XOR:  ref_wire.push_back(a ^ b);
			OP_XNOR: ref_wire.push_back(a ^ b ^ exp_r);
			default: ref_wire.push_back(a ^ exp_r); // NOT
		endcase
	end
	exp_mask = '0;
	for (int k = 0; k < n_out; k++)
		exp_mask = exp_mask | (label_t'(ref_wire[n_in + n_gates - n_out + k][0]) << k);
endfunction

`endif

// ==== bench/free_xor_garbler_tb.sv ====
/*
 * Testbench of the free-XOR garbler. Each table row becomes a netlist that
 * is streamed in with gaps, and the R, input label and mask words coming
 * back are compared with the reference model.
 */
`timescale 1ns/1ps
`default_nettype none

module free_xor_garbler_tb
	import netlist_pkg::*;
	import garble_pkg::*;
();

	// Rows of inputs, gates, outputs and chain flag
	localparam int NUM_ROWS = 5;
	localparam int ROW_IN [NUM_ROWS]    = '{8, 4, 16, 1, 30};
	localparam int ROW_GATES [NUM_ROWS] = '{40, 24, 100, 10, 60};
	localparam int ROW_OUT [NUM_ROWS]   = '{16, 8, 32, 10, 5};
	localparam bit ROW_CHAIN [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0};

	logic                 clk;
	logic                 rst;
	logic                 start;
	logic                 netlist_valid;
	logic [NL_WORD_W-1:0] netlist_in;
	tag_e                 tag;
	wire_idx_t            index;
	label_t               data;

	gate_op_e    g_op [$];
	int          g_in0 [$];
	int          g_in1 [$];
	logic [31:0] rand_state;

	`include "garble_model.svh"

	free_xor_garbler #(.MAX_WIRES(1024)) uut (
		.clk           (clk),
		.rst           (rst),
		.start         (start),
		.netlist_valid (netlist_valid),
		.netlist_in    (netlist_in),
		.tag           (tag),
		.index         (index),
		.data          (data)
	);

	always #20 clk = ~clk;

	// Galois LFSR stepped once per bit taken
	function automatic int rand_bits(int n);
		int v;
		v = 0;
		for (int b = 0; b < n; b++) begin
			v = (v << 1) | int'(rand_state[0]);
			rand_state = {1'b0, rand_state[31:1]} ^ (rand_state[0] ? 32'hA300_0000 : 32'h0);
		end
		return v;
	endfunction

	function automatic void make_gates(int n_in, int n_gates, bit chain);
		int span;
		g_op.delete();
		g_in0.delete();
		g_in1.delete();
		for (int j = 0; j < n_gates; j++) begin
			span = n_in + j; // Only wires below the gate's own
			if (chain) begin
				g_op.push_back(gate_op_e'(j % 3));
				g_in0.push_back(span - 1); // Previous gate or the last input
				g_in1.push_back((3 * j + 1) % span);
			end else begin
				g_op.push_back(gate_op_e'(rand_bits(2) % 3));
				g_in0.push_back(rand_bits(10) % span);
				g_in1.push_back(rand_bits(10) % span);
			end
		end
	endfunction

	function automatic int watchdog_cycles();
		int cyc;
		cyc = 10 + 200; // Reset and margin
		for (int r = 0; r < NUM_ROWS; r++)
			cyc += 20 * (2 + ROW_IN[r] + 2 * ROW_GATES[r]);
		return cyc;
	endfunction

	task automatic stop_on_error();
		$display("Test FAILED");
		$fatal(1, "Stopped at the first mismatch");
	endtask

	task automatic check_tag(tag_e got, tag_e exp, string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s has tag %b, expected %b", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_index(wire_idx_t got, wire_idx_t exp, string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_label(label_t got, label_t exp, string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic send_netlist(int n_in, int n_gates, int n_out);
		logic [NL_WORD_W-1:0] word;
		@(posedge clk); #1;
		start = 1'b1;
		@(posedge clk); #1;
		start = 1'b0;
		for (int w = 0; w <= n_gates; w++) begin
			if (w == 0)
				word = {2'b00, 10'(n_in), 10'(n_gates), 10'(n_out)};
			else
				word = {g_op[w-1], 10'b0, 10'(g_in0[w-1]), 10'(g_in1[w-1])};
			if (rand_bits(2) == 3) begin // Occasional gap in the stream
				netlist_valid = 1'b0;
				@(posedge clk); #1;
				check_tag(tag, TAG_NONE, "idle output during load");
			end
			netlist_valid = 1'b1;
			netlist_in    = word;
			@(posedge clk); #1;
			check_tag(tag, TAG_NONE, "idle output during load");
		end
		netlist_valid = 1'b0;
		netlist_in    = '0;
	endtask

	task automatic collect_words(int n_in);
		while (tag == TAG_NONE) begin
			@(posedge clk); #1;
		end
		check_tag(tag, TAG_R, "first word");
		check_label(data, exp_r, "R label");
		// Input labels follow back to back
		for (int i = 0; i < n_in; i++) begin
			@(posedge clk); #1;
			check_tag(tag, TAG_INPUT, "input word");
			check_index(index, wire_idx_t'(i), "input index");
			check_label(data, exp_in[i], "input label");
		end
		@(posedge clk); #1;
		while (tag == TAG_NONE) begin
			@(posedge clk); #1;
		end
		check_tag(tag, TAG_MASK, "word after the inputs");
		check_index(index, '0, "mask index");
		check_label(data, exp_mask, "output mask");
		@(posedge clk); #1;
		check_tag(tag, TAG_NONE, "word after the mask");
	endtask

	initial begin
		#(watchdog_cycles() * 40);
		$display("Timeout: the garbler produced no mask word in time");
		$display("Test FAILED");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		clk           = 1'b0;
		rst           = 1'b1;
		start         = 1'b0;
		netlist_valid = 1'b0;
		netlist_in    = '0;
		rand_state    = 32'hf96f_3d97;
		ref_lfsr      = REF_SEED;
		repeat (5) begin
			@(posedge clk); #1;
			check_tag(tag, TAG_NONE, "output during reset");
		end
		rst = 1'b0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			make_gates(ROW_IN[r], ROW_GATES[r], ROW_CHAIN[r]);
			build_expected(ROW_IN[r], ROW_GATES[r], ROW_OUT[r]);
			send_netlist(ROW_IN[r], ROW_GATES[r], ROW_OUT[r]);
			collect_words(ROW_IN[r]);
		end
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== free_xor_garbler.f ====
logic/netlist_pkg.sv
logic/garble_pkg.sv
logic/gate_read_if.sv
logic/netlist_loader.sv
logic/gate_store.sv
logic/label_gen.sv
logic/xor_garbler.sv
logic/free_xor_garbler.sv
+incdir+bench
bench/free_xor_garbler_tb.sv

// ==== logic/free_xor_garbler.sv ====
/*
 * Top level of the free-XOR garbler. A netlist streams in after start and
 * the garbled words stream out on tag, index and data. The consumer must
 * take every word with a nonzero tag, there is no back-pressure.
 */
`timescale 1ns/1ps
`default_nettype none

module free_xor_garbler
	import netlist_pkg::*;
	import garble_pkg::*;
#(
	parameter int MAX_WIRES = 1024
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  logic                 netlist_valid,
	input  logic [NL_WORD_W-1:0] netlist_in,
	output tag_e                 tag,
	output wire_idx_t            index,
	output label_t               data
);

	logic                 hdr_en;
	logic [NL_WORD_W-1:0] hdr_word;
	logic                 wr_en;
	wire_idx_t            wr_addr;
	gate_rec_t            wr_gate;
	logic                 loaded;
	logic                 label_en;
	label_t               label;

	gate_read_if rd_bus ();

	netlist_loader loader (
		.clk           (clk),
		.rst           (rst),
		.start         (start),
		.netlist_valid (netlist_valid),
		.netlist_in    (netlist_in),
		.hdr_en        (hdr_en),
		.hdr_word      (hdr_word),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_gate       (wr_gate),
		.loaded        (loaded)
	);

	gate_store #(.MAX_WIRES(MAX_WIRES)) store (
		.clk      (clk),
		.rst      (rst),
		.hdr_en   (hdr_en),
		.hdr_word (hdr_word),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_gate  (wr_gate),
		.loaded   (loaded),
		.rd       (rd_bus)
	);

	label_gen labels (
		.clk      (clk),
		.rst      (rst),
		.label_en (label_en),
		.label    (label)
	);

	xor_garbler #(.MAX_WIRES(MAX_WIRES)) garbler (
		.clk      (clk),
		.rst      (rst),
		.rd       (rd_bus),
		.label_en (label_en),
		.label    (label),
		.tag      (tag),
		.index    (index),
		.data     (data)
	);

endmodule

`default_nettype wire

// ==== logic/garble_pkg.sv ====
/*
 * Label and output stream definitions of the free-XOR garbler.
 * Holds the label width, the LFSR constants, the output word tags
 * and the garbler FSM states.
 */
`default_nettype none

package garble_pkg;

	localparam int LABEL_W = 32;

	typedef logic [LABEL_W-1:0] label_t;

	localparam label_t LABEL_SEED = 32'h1;
	localparam label_t LABEL_TAPS = 32'h8020_0003; // Galois feedback mask

	// Tag of the output word, nonzero when the word is valid
	typedef enum logic [2:0] {
		TAG_NONE  = 3'b000,
		TAG_R     = 3'b001,
		TAG_INPUT = 3'b101,
		TAG_MASK  = 3'b011
	} tag_e;

	typedef enum logic [2:0] {
		IDLE,
		SEND_R,
		INPUT_LABELS,
		GARBLE,
		DRAIN,
		MASK
	} garble_state_e;

endpackage

`default_nettype wire

// ==== logic/gate_read_if.sv ====
/*
 * Read path from the gate store to the garbler.
 * The garbler gives a gate address, the store returns the record one
 * cycle later together with the header counts and the load pulse.
 */
`timescale 1ns/1ps
`default_nettype none

interface gate_read_if
	import netlist_pkg::*;
();

	wire_idx_t rd_addr;
	gate_rec_t rd_gate;      // Valid one cycle after rd_addr
	wire_idx_t input_count;
	wire_idx_t gate_count;
	wire_idx_t output_count;
	logic      loaded;

	modport store (
		input  rd_addr,
		output rd_gate, input_count, gate_count, output_count, loaded
	);

	modport garbler (
		output rd_addr,
		input  rd_gate, input_count, gate_count, output_count, loaded
	);

endinterface

`default_nettype wire

// ==== logic/gate_store.sv ====
/*
 * Gate record memory with one write port from the loader and one
 * registered read port for the garbler. Also keeps the circuit counts
 * decoded from the header word.
 */
`timescale 1ns/1ps
`default_nettype none

module gate_store
	import netlist_pkg::*;
#(
	parameter int MAX_WIRES = 1024
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 hdr_en,
	input  logic [NL_WORD_W-1:0] hdr_word,
	input  logic                 wr_en,
	input  wire_idx_t            wr_addr,
	input  gate_rec_t            wr_gate,
	input  logic                 loaded,
	gate_read_if.store           rd
);

	gate_rec_t gates [MAX_WIRES];

	always_ff @(posedge clk) begin
		if (wr_en)
			gates[wr_addr] <= wr_gate;
		rd.rd_gate <= gates[rd.rd_addr]; // One cycle read latency
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd.input_count  <= '0;
			rd.gate_count   <= '0;
			rd.output_count <= '0;
		end else if (hdr_en) begin
			rd.input_count  <= hdr_word[HDR_IN_MSB:HDR_IN_LSB];
			rd.gate_count   <= hdr_word[HDR_GATE_MSB:HDR_GATE_LSB];
			rd.output_count <= hdr_word[HDR_OUT_MSB:HDR_OUT_LSB];
		end
	end

	// Garbler starts once the whole netlist sits in memory
	assign rd.loaded = loaded;

endmodule

`default_nettype wire

// ==== logic/label_gen.sv ====
/*
 * Fresh label source. A Galois LFSR steps once per enable and the new
 * state is the label, visible in the cycle after the enable.
 * Only rst reseeds it, so labels keep running across netlists.
 */
`timescale 1ns/1ps
`default_nettype none

module label_gen
	import garble_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   label_en,
	output label_t label
);

	label_t next_label;

	// Shift right, fold in the taps when a one drops out
	assign next_label = {1'b0, label[LABEL_W-1:1]} ^ (label[0] ? LABEL_TAPS : '0);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			label <= LABEL_SEED;
		else if (label_en)
			label <= next_label;
	end

endmodule

`default_nettype wire

// ==== logic/netlist_loader.sv ====
/*
 * Takes a netlist after a start pulse: the header on the first valid word,
 * then one gate per valid word. Gate words are unpacked into records and
 * written to the gate store, and loaded pulses with the last record.
 */
`timescale 1ns/1ps
`default_nettype none

module netlist_loader
	import netlist_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  logic                 netlist_valid,
	input  logic [NL_WORD_W-1:0] netlist_in,
	output logic                 hdr_en,
	output logic [NL_WORD_W-1:0] hdr_word,
	output logic                 wr_en,
	output wire_idx_t            wr_addr,
	output gate_rec_t            wr_gate,
	output logic                 loaded
);

	typedef enum logic [1:0] {LD_IDLE, LD_HEADER, LD_GATES} load_state_e;

	load_state_e state;
	wire_idx_t   gate_cnt;
	wire_idx_t   gate_total;
	wire_idx_t   hdr_gates;

	assign hdr_gates = netlist_in[HDR_GATE_MSB:HDR_GATE_LSB];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state      <= LD_IDLE;
			gate_cnt   <= '0;
			gate_total <= '0;
			hdr_en     <= 1'b0;
			wr_en      <= 1'b0;
			loaded     <= 1'b0;
		end else begin
			hdr_en <= 1'b0;
			wr_en  <= 1'b0;
			loaded <= 1'b0;
			case (state)
				LD_IDLE: if (start) state <= LD_HEADER; // Start ignored while busy
				LD_HEADER: if (netlist_valid) begin
					hdr_en     <= 1'b1;
					gate_total <= hdr_gates;
					gate_cnt   <= '0;
					if (hdr_gates == '0) begin
						loaded <= 1'b1; // Empty netlist
						state  <= LD_IDLE;
					end else begin
						state <= LD_GATES;
					end
				end
				LD_GATES: if (netlist_valid) begin
					wr_en    <= 1'b1;
					gate_cnt <= gate_cnt + 1'b1;
					if (gate_cnt == gate_total - 1'b1) begin
						loaded <= 1'b1;
						state  <= LD_IDLE;
					end
				end
				default: state <= LD_IDLE;
			endcase
		end
	end

	// Word payload, qualified by hdr_en and wr_en
	always_ff @(posedge clk) begin
		hdr_word    <= netlist_in;
		wr_addr     <= gate_cnt;
		wr_gate.op  <= gate_op_e'(netlist_in[GW_OP_MSB:GW_OP_LSB]);
		wr_gate.in0 <= netlist_in[GW_IN0_MSB:GW_IN0_LSB];
		wr_gate.in1 <= netlist_in[GW_IN1_MSB:GW_IN1_LSB];
	end

endmodule

`default_nettype wire

// ==== logic/netlist_pkg.sv ====
/*
 * Netlist word formats shared by the loader, the gate store and the garbler.
 * A netlist is one header word followed by one word per gate, each gate
 * naming its opcode and two lower-numbered input wires.
 */
`default_nettype none

package netlist_pkg;

	localparam int NL_WORD_W  = 32;
	localparam int WIRE_IDX_W = 10;

	typedef logic [WIRE_IDX_W-1:0] wire_idx_t;

	// Free-XOR gate types only
	typedef enum logic [1:0] {
		OP_XOR  = 2'd0,
		OP_XNOR = 2'd1,
		OP_NOT  = 2'd2
	} gate_op_e;

	typedef struct packed {
		gate_op_e  op;
		wire_idx_t in0;
		wire_idx_t in1; // Ignored by NOT
	} gate_rec_t;

	// Header word fields
	localparam int HDR_IN_MSB   = 29;
	localparam int HDR_IN_LSB   = 20;
	localparam int HDR_GATE_MSB = 19;
	localparam int HDR_GATE_LSB = 10;
	localparam int HDR_OUT_MSB  = 9;
	localparam int HDR_OUT_LSB  = 0;

	// Gate word fields, bits 29 to 20 unused
	localparam int GW_OP_MSB  = 31;
	localparam int GW_OP_LSB  = 30;
	localparam int GW_IN0_MSB = 19;
	localparam int GW_IN0_LSB = 10;
	localparam int GW_IN1_MSB = 9;
	localparam int GW_IN1_LSB = 0;

endpackage

`default_nettype wire

// ==== logic/xor_garbler.sv ====
/*
 * Free-XOR garbler core. After a netlist is loaded it sends R, then one
 * zero-label per circuit input, garbles the gates in order and ends with
 * the output mask word. All words leave registered, tagged by tag.
 */
`timescale 1ns/1ps
`default_nettype none

module xor_garbler
	import netlist_pkg::*;
	import garble_pkg::*;
#(
	parameter int MAX_WIRES = 1024
) (
	input  logic        clk,
	input  logic        rst,
	gate_read_if.garbler rd,
	output logic        label_en,
	input  label_t      label,
	output tag_e        tag,
	output wire_idx_t   index,
	output label_t      data
);

	garble_state_e state, state_n;
	wire_idx_t     cnt, cnt_n;     // SEND_R phase, input number or gate address
	wire_idx_t     last_input;
	wire_idx_t     last_gate;
	wire_idx_t     first_out;
	logic          r_en;
	logic          mask_clr;
	logic          issue;
	tag_e          tag_n;
	wire_idx_t     index_n;
	label_t        data_n;

	label_t        r_label;
	label_t        r_fresh;
	label_t        mask_sr;
	logic          iss_v;          // Record for gate iss_idx on rd_gate
	wire_idx_t     iss_idx;
	logic          is_out;

	label_t        label_mem [MAX_WIRES];
	logic          lm_we;
	wire_idx_t     lm_addr;
	label_t        lm_data;
	label_t        in0_label;
	label_t        in1_label;
	label_t        gate_label;

	assign rd.rd_addr  = cnt;
	assign last_input  = rd.input_count - 1'b1;
	assign last_gate   = rd.gate_count - 1'b1;
	assign first_out   = rd.gate_count - rd.output_count;
	assign r_fresh     = {label[LABEL_W-1:1], 1'b1}; // Point-and-permute bit of R is 1

	always_comb begin
		state_n  = state;
		cnt_n    = cnt;
		label_en = 1'b0;
		r_en     = 1'b0;
		mask_clr = 1'b0;
		issue    = 1'b0;
		tag_n    = TAG_NONE;
		index_n  = '0;
		data_n   = '0;
		case (state)
			IDLE: if (rd.loaded) begin
				state_n = SEND_R;
				cnt_n   = '0;
			end
			SEND_R: begin
				if (cnt == '0) begin
					label_en = 1'b1; // Step for R
					cnt_n    = cnt + 1'b1;
				end else begin
					r_en     = 1'b1;
					mask_clr = 1'b1;
					tag_n    = TAG_R;
					data_n   = r_fresh;
					label_en = (rd.input_count != '0); // Prefetch label of input 0
					cnt_n    = '0;
					if (rd.input_count != '0)
						state_n = INPUT_LABELS;
					else if (rd.gate_count != '0)
						state_n = GARBLE;
					else
						state_n = MASK;
				end
			end
			INPUT_LABELS: begin
				tag_n   = TAG_INPUT;
				index_n = cnt;
				data_n  = label;
				if (cnt == last_input) begin
					cnt_n   = '0;
					state_n = (rd.gate_count != '0) ? GARBLE : MASK;
				end else begin
					label_en = 1'b1;
					cnt_n    = cnt + 1'b1;
				end
			end
			GARBLE: begin
				issue = 1'b1; // One gate address per cycle
				cnt_n = cnt + 1'b1;
				if (cnt == last_gate)
					state_n = DRAIN;
			end
			DRAIN: state_n = MASK; // Last gate is written here
			MASK: begin
				tag_n   = TAG_MASK;
				data_n  = mask_sr >> (LABEL_W - rd.output_count);
				state_n = IDLE;
			end
			default: state_n = IDLE;
		endcase
	end

	// Wire labels, read combinationally so a gate sees the one just before it
	assign in0_label = label_mem[rd.rd_gate.in0];
	assign in1_label = label_mem[rd.rd_gate.in1];

	always_comb begin
		case (rd.rd_gate.op)
			OP_XNOR: gate_label = in0_label ^ in1_label ^ r_label;
			OP_NOT:  gate_label = in0_label ^ r_label;
			default: gate_label = in0_label ^ in1_label;
		endcase
	end

	// Input labels go to wires 0 to I-1, gate j drives wire I+j
	assign lm_we   = (state == INPUT_LABELS) || iss_v;
	assign lm_addr = iss_v ? rd.input_count + iss_idx : cnt;
	assign lm_data = iss_v ? gate_label : label;
	assign is_out  = iss_v && (iss_idx >= first_out);

	always_ff @(posedge clk) begin
		if (lm_we)
			label_mem[lm_addr] <= lm_data;
	end

	always_ff @(posedge clk) begin
		iss_idx <= cnt;
		if (r_en)
			r_label <= r_fresh;
		// First output ends up at bit 0 after the final shift in MASK
		if (mask_clr)
			mask_sr <= '0;
		else if (is_out)
			mask_sr <= {gate_label[0], mask_sr[LABEL_W-1:1]};
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
			cnt   <= '0;
			iss_v <= 1'b0;
			tag   <= TAG_NONE;
			index <= '0;
			data  <= '0;
		end else begin
			state <= state_n;
			cnt   <= cnt_n;
			iss_v <= issue;
			tag   <= tag_n;
			index <= index_n;
			data  <= data_n;
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f free_xor_garbler.f --top-module free_xor_garbler_tb \
	-Mdir obj_dir -o sim_garbler > build.log 2>&1 &&
{ ./obj_dir/sim_garbler > sim.log 2>&1 || true; } &&
grep -q "^Test OK$" sim.log &&
echo "PASS" ||
{ echo "FAIL, see build.log and sim.log"; exit 1; }
